// File: tb.f
+incdir+hw
hw/issue_pkg.sv
hw/scoreboard.sv
hw/dispatch_stage.sv
hw/reservation_station.sv
hw/register_file.sv
hw/operand_fetch.sv
hw/issue_stage.sv
verif/issue_checker.sv
verif/tb_issue.sv

// File: verif/tb_issue.sv
// Testbench top that drives random renamed traffic into the issue stage and returns writebacks
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module tb_issue import issue_pkg::*; ();

	localparam int NUM_TICKETS   = 1 << `ISSUE_TICKET_BITS;
	localparam int RING          = 16;
	localparam int DRAIN_TIMEOUT = 1000;

	logic                               clk;
	logic                               rst_n;
	logic                               instr_valid;
	renamed_instr_t                     instr;
	logic                               accept;
	wb_update_t   [`ISSUE_NUM_FU-1:0]   wb;
	logic         [`ISSUE_NUM_FU-1:0]   busy;
	logic                               flush;
	exec_packet_t [`ISSUE_NUM_FU-1:0]   exec;
	int                                 chk_errors;
	int                                 chk_outstanding;

	logic [31:0]                lcg_state;
	logic [`ISSUE_NUM_REGS-1:0] written;
	logic [`ISSUE_NUM_REGS-1:0] inuse;
	int                         readers [`ISSUE_NUM_REGS];
	tag_t                       tk_src1 [NUM_TICKETS];
	tag_t                       tk_src2 [NUM_TICKETS];
	logic                       tk_use1 [NUM_TICKETS];
	logic                       tk_use2 [NUM_TICKETS];
	logic [NUM_TICKETS-1:0]     tk_live;
	tag_t                       rb_dest [`ISSUE_NUM_FU][RING];
	data_t                      rb_data [`ISSUE_NUM_FU][RING];
	int                         rb_due  [`ISSUE_NUM_FU][RING];
	int                         rb_head [`ISSUE_NUM_FU];
	int                         rb_tail [`ISSUE_NUM_FU];
	int                         last_due [`ISSUE_NUM_FU];
	int                         cycle;
	int                         tb_errors;
	int                         waited;
	ticket_t                    next_ticket;
	logic                       flush_req;

	issue_stage i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.accept      (accept),
		.wb          (wb),
		.busy        (busy),
		.flush       (flush),
		.exec        (exec)
	);

	issue_checker i_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.accept      (accept),
		.wb          (wb),
		.busy        (busy),
		.flush       (flush),
		.exec        (exec),
		.errors      (chk_errors),
		.outstanding (chk_outstanding)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] v;
		v = lcg_next();
		return int'(v[30:8]) % n;
	endfunction

	function automatic logic rings_empty();
		logic empty;
		empty = 1'b1;
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			if (rb_head[i] != rb_tail[i]) begin
				empty = 1'b0;
			end
		end
		return empty;
	endfunction

	// Destination never pending and never read by a waiting instruction
	// A ticket is reused only after its packet has left for execution
	task automatic issue_new_instr();
		renamed_instr_t ni;
		int r;
		logic found;
		if (tk_live[next_ticket]) begin
			instr_valid <= 1'b0;
			return;
		end
		found = 1'b0;
		r = 0;
		for (int k = 0; k < 8; k++) begin
			if (!found) begin
				r = 1 + rand_below(`ISSUE_NUM_REGS - 1);
				found = !inuse[r] && (readers[r] == 0);
			end
		end
		if (!found) begin
			instr_valid <= 1'b0;
			return;
		end
		ni.ticket = next_ticket;
		ni.pc     = lcg_next();
		ni.dest   = tag_t'(r);
		ni.src1   = tag_t'(rand_below(`ISSUE_NUM_REGS));
		ni.src2   = tag_t'(rand_below(`ISSUE_NUM_REGS));
		if (!written[ni.src1] || (ni.src1 == ni.dest)) ni.src1 = '0;
		if (!written[ni.src2] || (ni.src2 == ni.dest)) ni.src2 = '0;
		ni.immediate   = lcg_next();
		ni.fu          = fu_t'(rand_below(4));
		ni.uop         = uop_t'(rand_below(32));
		ni.src1_is_pc  = (rand_below(4) == 0);
		ni.src2_is_imm = (rand_below(4) == 0);
		inuse[r] = 1'b1;
		tk_live[ni.ticket] = 1'b1;
		tk_src1[ni.ticket] = ni.src1;
		tk_src2[ni.ticket] = ni.src2;
		tk_use1[ni.ticket] = !ni.src1_is_pc;
		tk_use2[ni.ticket] = !ni.src2_is_imm;
		if (!ni.src1_is_pc) readers[ni.src1]++;
		if (!ni.src2_is_imm) readers[ni.src2]++;
		next_ticket++;
		instr       <= ni;
		instr_valid <= 1'b1;
	endtask

	// Advances one clock cycle and drives the inputs for the next one
	// Busy mode 0 clears every unit, 1 toggles at random and 2 holds all units busy
	task automatic step(input logic gen_en, input int busy_mode);
		logic taken;
		int t;
		int d;
		wb_update_t [`ISSUE_NUM_FU-1:0] wb_n;
		logic [`ISSUE_NUM_FU-1:0] busy_n;
		@(posedge clk);
		cycle++;
		taken = instr_valid && accept;
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			if (exec[i].valid) begin
				t = exec[i].ticket;
				tk_live[t] = 1'b0;
				if (tk_use1[t]) readers[tk_src1[t]]--;
				if (tk_use2[t]) readers[tk_src2[t]]--;
				d = cycle + 1 + rand_below(4);
				if (d < last_due[i]) d = last_due[i];
				last_due[i] = d;
				rb_dest[i][rb_tail[i]] = exec[i].dest;
				rb_data[i][rb_tail[i]] = lcg_next();
				rb_due[i][rb_tail[i]]  = d;
				rb_tail[i] = (rb_tail[i] + 1) % RING;
			end
			wb_n[i] = '0;
			if ((rb_head[i] != rb_tail[i]) && (rb_due[i][rb_head[i]] <= cycle)) begin
				wb_n[i].valid = 1'b1;
				wb_n[i].dest  = rb_dest[i][rb_head[i]];
				wb_n[i].data  = rb_data[i][rb_head[i]];
				written[wb_n[i].dest] = 1'b1;
				inuse[wb_n[i].dest]   = 1'b0;
				rb_head[i] = (rb_head[i] + 1) % RING;
			end
			busy_n[i] = (busy_mode == 2);
			if (busy_mode == 1) begin
				busy_n[i] = (rand_below(16) == 0) ? !busy[i] : busy[i];
			end
		end
		wb    <= wb_n;
		busy  <= busy_n;
		flush <= flush_req;
		if (!gen_en) begin
			instr_valid <= 1'b0;
		end else if (taken || !instr_valid) begin
			if (rand_below(4) != 0) begin
				issue_new_instr();
			end else begin
				instr_valid <= 1'b0;
			end
		end
	endtask

	initial begin
		lcg_state   = 32'h4b4628c6;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		wb          = '0;
		busy        = '0;
		flush       = 1'b0;
		flush_req   = 1'b0;
		written     = '0;
		written[0]  = 1'b1;
		inuse       = '0;
		tk_live     = '0;
		next_ticket = '0;
		cycle       = 0;
		tb_errors   = 0;
		for (int r = 0; r < `ISSUE_NUM_REGS; r++) readers[r] = 0;
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			rb_head[i]  = 0;
			rb_tail[i]  = 0;
			last_due[i] = 0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		repeat (400) step(1'b1, 1);

		// Fill the stations behind busy units, then flush them
		repeat (10) step(1'b1, 2);
		repeat (3) step(1'b0, 2);
		waited = 0;
		while (!rings_empty() && (waited < DRAIN_TIMEOUT)) begin
			step(1'b0, 2);
			waited++;
		end
		if (waited >= DRAIN_TIMEOUT) begin
			$display("Writebacks did not drain before the flush");
			tb_errors++;
		end
		flush_req = 1'b1;
		step(1'b0, 2);
		flush_req = 1'b0;
		step(1'b0, 0);
		inuse   = '0;
		tk_live = '0;
		for (int r = 0; r < `ISSUE_NUM_REGS; r++) readers[r] = 0;

		repeat (300) step(1'b1, 1);

		waited = 0;
		step(1'b0, 0);
		@(negedge clk);
		while (((chk_outstanding != 0) || !rings_empty()) && (waited < DRAIN_TIMEOUT)) begin
			step(1'b0, 0);
			@(negedge clk);
			waited++;
		end
		if (waited >= DRAIN_TIMEOUT) begin
			$display("Instructions still waiting after %0d drain cycles", DRAIN_TIMEOUT);
			tb_errors++;
		end
		repeat (6) step(1'b0, 0);

		$display("Summary: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
		if ((chk_errors == 0) && (tb_errors == 0)) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/issue_checker.sv
// Reference model of the issue stage, compares every exec packet and the accept flag
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module issue_checker import issue_pkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic                                instr_valid,
	input  wire renamed_instr_t                      instr,
	input  wire logic                                accept,
	input  wire wb_update_t   [`ISSUE_NUM_FU-1:0]    wb,
	input  wire logic         [`ISSUE_NUM_FU-1:0]    busy,
	input  wire logic                                flush,
	input  wire exec_packet_t [`ISSUE_NUM_FU-1:0]    exec,
	output int                                       errors,
	output int                                       outstanding
);

	localparam int NUM_TICKETS   = 1 << `ISSUE_TICKET_BITS;
	localparam int ISSUE_TIMEOUT = 500;

	data_t                      model_regs [`ISSUE_NUM_REGS];
	logic [`ISSUE_NUM_REGS-1:0] model_pending;
	renamed_instr_t             waiting [NUM_TICKETS];
	logic [NUM_TICKETS-1:0]     live;
	logic [NUM_TICKETS-1:0]     killed;
	int                         age [NUM_TICKETS];
	logic [`ISSUE_NUM_FU-1:0]   busy_d;

	// Exec port of each unit code, branch shares the integer port
	function automatic int unit_port(input fu_t fu);
		case (fu)
			2'd0:    return 0;
			2'd1:    return 2;
			default: return 1;
		endcase
	endfunction

	task automatic report_value(input string name, input int t, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Error: %s ticket %0d expected %h actual %h", name, t, exp, act);
		errors++;
	endtask

	always @(posedge clk or negedge rst_n) begin
		int t;
		int cnt [`ISSUE_NUM_FU];
		renamed_instr_t e;
		logic exp_acc;
		if (!rst_n) begin
			for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
				model_regs[r] = '0;
			end
			model_pending = '0;
			live          = '0;
			killed        = '0;
			busy_d        = '0;
			errors        = 0;
			outstanding   = 0;
		end else begin
			// Packets registered at the previous edge
			for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
				if (exec[i].valid) begin
					t = exec[i].ticket;
					if (busy_d[i]) begin
						$display("Exec port %0d issued while its unit was busy", i);
						errors++;
					end
					if (killed[t]) begin
						$display("Flushed ticket %0d reached exec port %0d", t, i);
						errors++;
					end else if (!live[t]) begin
						$display("Ticket %0d reached exec port %0d but was not waiting", t, i);
						errors++;
					end else begin
						e = waiting[t];
						if (unit_port(e.fu) != i) begin
							report_value("routing", t, unit_port(e.fu), i);
						end
						if ((!e.src1_is_pc && model_pending[e.src1]) ||
								(!e.src2_is_imm && model_pending[e.src2])) begin
							$display("Ticket %0d issued before its sources were written back", t);
							errors++;
						end
						if (exec[i].data1 !== (e.src1_is_pc ? e.pc : model_regs[e.src1])) begin
							report_value("data1", t,
								e.src1_is_pc ? e.pc : model_regs[e.src1], exec[i].data1);
						end
						if (exec[i].data2 !== (e.src2_is_imm ? e.immediate : model_regs[e.src2])) begin
							report_value("data2", t,
								e.src2_is_imm ? e.immediate : model_regs[e.src2], exec[i].data2);
						end
						if (exec[i].dest !== e.dest) begin
							report_value("dest", t, e.dest, exec[i].dest);
						end
						if (exec[i].uop !== e.uop) begin
							report_value("uop", t, e.uop, exec[i].uop);
						end
						live[t] = 1'b0;
					end
				end
			end

			// Station occupancy during the ending cycle
			for (int s = 0; s < `ISSUE_NUM_FU; s++) begin
				cnt[s] = 0;
			end
			for (int k = 0; k < NUM_TICKETS; k++) begin
				if (live[k]) begin
					cnt[unit_port(waiting[k].fu)]++;
				end
			end
			if (instr_valid && !flush) begin
				exp_acc = cnt[unit_port(instr.fu)] < `ISSUE_RS_DEPTH;
				if (accept !== exp_acc) begin
					report_value("accept", instr.ticket, exp_acc, accept);
				end
			end
			if (flush && accept) begin
				$display("Accept was high during a flush");
				errors++;
			end

			for (int k = 0; k < NUM_TICKETS; k++) begin
				if (live[k]) begin
					age[k]++;
					if (age[k] == ISSUE_TIMEOUT) begin
						$display("Ticket %0d not issued within %0d cycles", k, ISSUE_TIMEOUT);
						errors++;
					end
				end
			end

			for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
				if (wb[i].valid) begin
					model_regs[wb[i].dest] = wb[i].data;
				end
			end
			if (flush) begin
				model_pending = '0;
				killed        = killed | live;
				live          = '0;
			end else begin
				for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
					if (wb[i].valid) begin
						model_pending[wb[i].dest] = 1'b0;
					end
				end
				if (instr_valid && accept) begin
					if (instr.dest != '0) begin
						model_pending[instr.dest] = 1'b1;
					end
					t          = instr.ticket;
					live[t]    = 1'b1;
					killed[t]  = 1'b0;
					waiting[t] = instr;
					age[t]     = 0;
				end
			end

			busy_d      = busy;
			outstanding = 0;
			for (int k = 0; k < NUM_TICKETS; k++) begin
				if (live[k]) begin
					outstanding++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
// Top of the issue stage: dispatch, three reservation stations and operand fetch
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module issue_stage import issue_pkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic                                instr_valid,
	input  wire renamed_instr_t                      instr,
	output logic                                     accept,
	input  wire wb_update_t   [`ISSUE_NUM_FU-1:0]    wb,
	input  wire logic         [`ISSUE_NUM_FU-1:0]    busy,
	input  wire logic                                flush,
	output exec_packet_t      [`ISSUE_NUM_FU-1:0]    exec
);

	logic           [`ISSUE_NUM_FU-1:0] station_free;
	logic           [`ISSUE_NUM_FU-1:0] push;
	rs_entry_t                          entry;
	logic           [`ISSUE_NUM_FU-1:0] sel_valid;
	renamed_instr_t [`ISSUE_NUM_FU-1:0] sel_entry;

	dispatch_stage i_dispatch (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.accept       (accept),
		.wb           (wb),
		.flush        (flush),
		.station_free (station_free),
		.push         (push),
		.entry        (entry)
	);

	// Station 0 memory, 1 integer and branch, 2 float
	for (genvar s = 0; s < `ISSUE_NUM_FU; s++) begin : g_station
		reservation_station #(
			.DEPTH (`ISSUE_RS_DEPTH)
		) i_station (
			.clk       (clk),
			.rst_n     (rst_n),
			.push      (push[s]),
			.entry     (entry),
			.free      (station_free[s]),
			.wb        (wb),
			.busy      (busy[s]),
			.flush     (flush),
			.sel_valid (sel_valid[s]),
			.sel_entry (sel_entry[s])
		);
	end

	operand_fetch i_operand_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.sel_valid (sel_valid),
		.sel_entry (sel_entry),
		.wb        (wb),
		.exec      (exec)
	);

endmodule

`default_nettype wire

// File: hw/operand_fetch.sv
// Operand read for the selected entries and the registered packets sent to execution
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module operand_fetch import issue_pkg::*; (
	input  wire logic                                  clk,
	input  wire logic                                  rst_n,
	input  wire logic           [`ISSUE_NUM_FU-1:0]    sel_valid,
	input  wire renamed_instr_t [`ISSUE_NUM_FU-1:0]    sel_entry,
	input  wire wb_update_t     [`ISSUE_NUM_FU-1:0]    wb,
	output exec_packet_t        [`ISSUE_NUM_FU-1:0]    exec
);

	tag_t         [2*`ISSUE_NUM_FU-1:0] read_tag;
	data_t        [2*`ISSUE_NUM_FU-1:0] read_data;
	exec_packet_t [`ISSUE_NUM_FU-1:0]   pkt_d;
	exec_packet_t [`ISSUE_NUM_FU-1:0]   pkt_q;
	logic         [`ISSUE_NUM_FU-1:0]   valid_q;

	register_file i_register_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb        (wb),
		.read_tag  (read_tag),
		.read_data (read_data)
	);

	always_comb begin
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			read_tag[2*i]   = sel_entry[i].src1;
			read_tag[2*i+1] = sel_entry[i].src2;

			pkt_d[i].valid  = sel_valid[i];
			pkt_d[i].ticket = sel_entry[i].ticket;
			pkt_d[i].dest   = sel_entry[i].dest;
			pkt_d[i].uop    = sel_entry[i].uop;
			// PC and immediate replace the register value when flagged
			pkt_d[i].data1  = sel_entry[i].src1_is_pc ? sel_entry[i].pc : read_data[2*i];
			pkt_d[i].data2  = sel_entry[i].src2_is_imm ? sel_entry[i].immediate : read_data[2*i+1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= sel_valid;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			if (sel_valid[i]) begin
				pkt_q[i] <= pkt_d[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			exec[i]       = pkt_q[i];
			exec[i].valid = valid_q[i];
		end
	end

endmodule

`default_nettype wire

// File: hw/register_file.sv
// Physical register file, one write port per unit and two read ports per station
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module register_file import issue_pkg::*; (
	input  wire logic                                  clk,
	input  wire logic                                  rst_n,
	input  wire wb_update_t [`ISSUE_NUM_FU-1:0]        wb,
	input  wire tag_t       [2*`ISSUE_NUM_FU-1:0]      read_tag,
	output data_t           [2*`ISSUE_NUM_FU-1:0]      read_data
);

	data_t regs [`ISSUE_NUM_REGS];

	// Renaming never hands out the same tag to two units at once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
				if (wb[i].valid) begin
					regs[wb[i].dest] <= wb[i].data;
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 2 * `ISSUE_NUM_FU; p++) begin
			read_data[p] = regs[read_tag[p]];
		end
	end

endmodule

`default_nettype wire

// File: hw/reservation_station.sv
// Reservation station with tag wakeup and oldest-ready selection, one per functional unit
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module reservation_station import issue_pkg::*; #(
	parameter int DEPTH = `ISSUE_RS_DEPTH
) (
	input  wire logic                              clk,
	input  wire logic                              rst_n,
	input  wire logic                              push,
	input  wire rs_entry_t                         entry,
	output logic                                   free,
	input  wire wb_update_t [`ISSUE_NUM_FU-1:0]    wb,
	input  wire logic                              busy,
	input  wire logic                              flush,
	output logic                                   sel_valid,
	output renamed_instr_t                         sel_entry
);

	localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Collapsing queue, slot 0 holds the oldest entry
	rs_entry_t             ent_q [DEPTH];
	rs_entry_t             ent_n [DEPTH];
	rs_entry_t             woke  [DEPTH];
	logic [DEPTH-1:0]      valid_q;
	logic [DEPTH-1:0]      valid_n;
	logic [DEPTH-1:0]      ready;
	logic [IDX_BITS-1:0]   sel_idx;
	logic                  found;
	logic                  placed;

	assign free = !valid_q[DEPTH-1];

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			ready[i] = valid_q[i] && !ent_q[i].pending1 && !ent_q[i].pending2;
		end
	end

	// Lowest ready slot is the oldest ready entry
	always_comb begin
		sel_idx = '0;
		found   = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel_idx = IDX_BITS'(i);
				found   = 1'b1;
			end
		end
	end

	assign sel_valid = found && !busy;
	assign sel_entry = ent_q[sel_idx].instr;

	always_comb begin
		// Wakeup on writeback tags
		for (int i = 0; i < DEPTH; i++) begin
			woke[i] = ent_q[i];
			if (wb_hits(wb, ent_q[i].instr.src1)) begin
				woke[i].pending1 = 1'b0;
			end
			if (wb_hits(wb, ent_q[i].instr.src2)) begin
				woke[i].pending2 = 1'b0;
			end
		end

		// Close the gap left by the issued entry
		for (int i = 0; i < DEPTH - 1; i++) begin
			if (sel_valid && (i >= sel_idx)) begin
				ent_n[i]   = woke[i+1];
				valid_n[i] = valid_q[i+1];
			end else begin
				ent_n[i]   = woke[i];
				valid_n[i] = valid_q[i];
			end
		end
		ent_n[DEPTH-1]   = woke[DEPTH-1];
		valid_n[DEPTH-1] = valid_q[DEPTH-1] && !sel_valid;

		// New entry goes behind the youngest one
		placed = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (push && !placed && !valid_n[i]) begin
				ent_n[i]   = entry;
				valid_n[i] = 1'b1;
				placed     = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_n;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			ent_q[i] <= ent_n[i];
		end
	end

endmodule

`default_nettype wire

// File: hw/dispatch_stage.sv
// Dispatch of one renamed instruction per cycle into the memory, integer or float station
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module dispatch_stage import issue_pkg::*; (
	input  wire logic                              clk,
	input  wire logic                              rst_n,
	input  wire logic                              instr_valid,
	input  wire renamed_instr_t                    instr,
	output logic                                   accept,
	input  wire wb_update_t [`ISSUE_NUM_FU-1:0]    wb,
	input  wire logic                              flush,
	input  wire logic       [`ISSUE_NUM_FU-1:0]    station_free,
	output logic            [`ISSUE_NUM_FU-1:0]    push,
	output rs_entry_t                              entry
);

	logic [`ISSUE_NUM_REGS-1:0] pending;
	logic [`ISSUE_NUM_FU-1:0]   target;
	logic                       take;

	scoreboard i_scoreboard (
		.clk     (clk),
		.rst_n   (rst_n),
		.set     (take),
		.set_tag (instr.dest),
		.wb      (wb),
		.flush   (flush),
		.pending (pending)
	);

	// Station chosen by unit code
	always_comb begin
		target = '0;
		case (instr.fu)
			FU_LS:        target[ST_MEM] = 1'b1;
			FU_FP:        target[ST_FP]  = 1'b1;
			FU_INT, FU_BR: target[ST_INT] = 1'b1;
			default:      target = '0;
		endcase
	end

	assign accept = |(target & station_free) && !flush;
	assign take   = instr_valid && accept;
	assign push   = take ? target : '0;

	// A source written back this cycle is already in the register file at the push edge
	always_comb begin
		entry.instr    = instr;
		entry.pending1 = pending[instr.src1] && !wb_hits(wb, instr.src1) && !instr.src1_is_pc;
		entry.pending2 = pending[instr.src2] && !wb_hits(wb, instr.src2) && !instr.src2_is_imm;
	end

endmodule

`default_nettype wire

// File: hw/scoreboard.sv
// Pending bit per physical register, used by dispatch to tag waiting sources
`timescale 1ns/100ps
`default_nettype none

`include "issue_defs.svh"

module scoreboard import issue_pkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic                                set,
	input  wire tag_t                                set_tag,
	input  wire wb_update_t [`ISSUE_NUM_FU-1:0]      wb,
	input  wire logic                                flush,
	output logic            [`ISSUE_NUM_REGS-1:0]    pending
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else if (flush) begin
			// Nothing in flight survives a flush
			pending <= '0;
		end else begin
			for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
				if (wb[i].valid) begin
					pending[wb[i].dest] <= 1'b0;
				end
			end
			// A fresh allocation wins over a stale writeback of the same tag
			if (set && (set_tag != '0)) begin
				pending[set_tag] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/issue_pkg.sv
// Shared types of the issue stage, imported by the RTL modules and the testbench
`default_nettype none

`include "issue_defs.svh"

package issue_pkg;

	typedef logic [`ISSUE_TAG_BITS-1:0]    tag_t;
	typedef logic [`ISSUE_DATA_BITS-1:0]   data_t;
	typedef logic [31:0]                   pc_t;
	typedef logic [`ISSUE_TICKET_BITS-1:0] ticket_t;
	typedef logic [`ISSUE_UOP_BITS-1:0]    uop_t;
	typedef logic [1:0]                    fu_t;

	// Unit codes carried by an instruction
	localparam fu_t FU_LS  = 2'd0;
	localparam fu_t FU_FP  = 2'd1;
	localparam fu_t FU_INT = 2'd2;
	localparam fu_t FU_BR  = 2'd3;

	// Station and exec port numbering
	localparam int ST_MEM = 0;
	localparam int ST_INT = 1;
	localparam int ST_FP  = 2;

	typedef struct packed {
		ticket_t ticket;
		pc_t     pc;
		tag_t    dest;
		tag_t    src1;
		tag_t    src2;
		data_t   immediate;
		fu_t     fu;
		uop_t    uop;
		logic    src1_is_pc;
		logic    src2_is_imm;
	} renamed_instr_t;

	typedef struct packed {
		renamed_instr_t instr;
		logic           pending1;
		logic           pending2;
	} rs_entry_t;

	typedef struct packed {
		logic  valid;
		tag_t  dest;
		data_t data;
	} wb_update_t;

	typedef struct packed {
		logic    valid;
		ticket_t ticket;
		tag_t    dest;
		uop_t    uop;
		data_t   data1;
		data_t   data2;
	} exec_packet_t;

	// True when any valid writeback port targets the given tag
	function automatic logic wb_hits(input wb_update_t [`ISSUE_NUM_FU-1:0] w, input tag_t t);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
			if (w[i].valid && (w[i].dest == t)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

endpackage

`default_nettype wire

// File: hw/issue_defs.svh
// Design sizes and widths of the issue stage, included by the package and the RTL
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Physical register tag width and register count
`define ISSUE_TAG_BITS 6
`define ISSUE_NUM_REGS 64

// Operand and result width
`define ISSUE_DATA_BITS 32

// Functional units, one station and one writeback port each
`define ISSUE_NUM_FU 3

// Entries per reservation station
`define ISSUE_RS_DEPTH 4

// ROB ticket width
`define ISSUE_TICKET_BITS 4

// Micro-operation width
`define ISSUE_UOP_BITS 5

`endif
